//--- common/chip_pkg.sv
package chip_pkg;

  //--------------------------------------------------------------------
  // sizes
  //--------------------------------------------------------------------
  localparam int num_pads  = 8;                        // all pads carry gpio
  localparam int gpio_w    = num_pads;                 // one gpio bit per pad
  localparam int pad_ctl_w = 9;                        // attr + drive

  //--------------------------------------------------------------------
  // address map
  //--------------------------------------------------------------------
  localparam logic [31:0] pad_cfg_base = 32'h4002_0000;  // pad config slave
  localparam logic [31:0] gpio_base    = 32'h4003_0000;  // gpio slave
  localparam logic [31:0] base_mask    = 32'hffff_0000;  // slave select bits

  // pad config block offsets
  localparam logic [7:0] pad_cfg_off = 8'h00;          // pad n at 4*n
  localparam logic [7:0] irq_ctl_off = 8'h20;          // bit 0 host irq enable
  localparam logic [7:0] sig_off     = 8'h24;          // read only

  // gpio block offsets
  localparam logic [7:0] gpio_out_off  = 8'h00;
  localparam logic [7:0] gpio_in_off   = 8'h04;        // synchronized pads
  localparam logic [7:0] gpio_mask_off = 8'h08;        // irq mask
  localparam logic [7:0] gpio_stat_off = 8'h0c;        // sticky, write 1 to clear

  localparam logic [31:0] chip_signature = 32'hc0fe_e001;

  //--------------------------------------------------------------------
  // pad encodings
  //--------------------------------------------------------------------
  typedef enum logic [1:0] {
    mode_func  = 2'b00,                                // gpio bit
    mode_level = 2'b01,                                // static level bit
    mode_irq   = 2'b10,                                // host interrupt
    mode_input = 2'b11                                 // input only, drive 0
  } pad_mode_t;

  localparam logic [1:0] drv_out = 2'b10;
  localparam logic [1:0] drv_in  = 2'b11;

  //--------------------------------------------------------------------
  // bus types
  //--------------------------------------------------------------------
  typedef struct packed {
    logic [31:0] addr;
    logic        write;
    logic [31:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;                                  // unmapped address
  } bus_rsp_t;

  typedef struct packed {
    logic        sel;                                  // accept cycle only
    logic        write;
    logic [7:0]  offset;                               // low address byte
    logic [31:0] wdata;
  } slv_req_t;

  // pad configuration word, raw on the bus, fields at the pad
  typedef struct packed {
    logic [6:0] rsvd31;                                // 31:25
    logic       level;                                 // 24
    logic [2:0] rsvd23;                                // 23:21
    logic       override;                              // 20, use drive field
    logic [1:0] rsvd19;                                // 19:18
    pad_mode_t  mode;                                  // 17:16
    logic [6:0] rsvd15;                                // 15:9
    logic [6:0] attr;                                  // 8:2 to pad as is
    logic [1:0] drive;                                 // 1:0
  } pad_cfg_fld_t;

  typedef union packed {
    logic [31:0]  raw;
    pad_cfg_fld_t fld;
  } pad_cfg_u;

endpackage

//--- logic/reset_sync.sv
module reset_sync (
  input  logic hclk,
  input  logic nreset,                                 // raw pad reset
  output logic rst_sync_n                              // to every other block
);

  logic sync0;
  logic sync1;
  logic sync2;

  // release ripples through three flops
  always_ff @(posedge hclk or negedge nreset) begin
    if (!nreset) begin
      sync0 <= 1'b0;
      sync1 <= 1'b0;
      sync2 <= 1'b0;
    end else begin
      sync0 <= 1'b1;
      sync1 <= sync0;
      sync2 <= sync1;
    end
  end

  // assert at once, release on the third edge
  assign rst_sync_n = sync2 & nreset;

endmodule

//--- logic/bus_fabric.sv
module bus_fabric import chip_pkg::*; (
  input  logic        hclk,
  input  logic        rst_n,
  input  bus_req_t    req,                             // from outside master
  input  logic        req_valid,
  output logic        req_ready,
  output bus_rsp_t    rsp,
  output logic        rsp_valid,
  input  logic        rsp_ready,
  output slv_req_t    pad_req,                         // pad config slave
  input  logic [31:0] pad_rdata,
  output slv_req_t    gpio_req,                        // gpio slave
  input  logic [31:0] gpio_rdata
);

  logic     accept;
  logic     pad_hit;
  logic     gpio_hit;
  bus_rsp_t rsp_next;

  // same request to both slaves, only sel differs
  function automatic slv_req_t slv_build(input logic hit, input logic acc, input bus_req_t r);
    slv_req_t s;
    s.sel    = hit & acc;
    s.write  = r.write;
    s.offset = r.addr[7:0];
    s.wdata  = r.wdata;
    return s;
  endfunction

  //--------------------------------------------------------------------
  // handshake
  //--------------------------------------------------------------------
  // stall only while a response waits on the master
  assign req_ready = ~(rsp_valid & ~rsp_ready);
  assign accept    = req_valid & req_ready;

  //--------------------------------------------------------------------
  // decode
  //--------------------------------------------------------------------
  assign pad_hit  = (req.addr & base_mask) == pad_cfg_base;
  assign gpio_hit = (req.addr & base_mask) == gpio_base;

  assign pad_req  = slv_build(pad_hit, accept, req);
  assign gpio_req = slv_build(gpio_hit, accept, req);

  // pick slave read data, error outside both bases
  always_comb begin
    rsp_next.rdata = 32'h0;
    rsp_next.err   = 1'b0;
    if (pad_hit) begin
      rsp_next.rdata = pad_rdata;
    end else if (gpio_hit) begin
      rsp_next.rdata = gpio_rdata;
    end else begin
      rsp_next.err   = 1'b1;                           // rdata stays 0
    end
  end

  //--------------------------------------------------------------------
  // response register
  //--------------------------------------------------------------------
  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
    end else if (accept) begin
      rsp_valid <= 1'b1;                               // new one replaces sent one
    end else if (rsp_ready) begin
      rsp_valid <= 1'b0;                               // transferred
    end
  end

  // held stable until the next accept
  always_ff @(posedge hclk) begin
    if (accept) begin
      rsp <= rsp_next;
    end
  end

endmodule

//--- padring/pad_cfg_regs.sv
module pad_cfg_regs import chip_pkg::*; (
  input  logic        hclk,
  input  logic        rst_n,
  input  slv_req_t    slv,
  input  logic        gpio_irq,                        // or of gpio status
  output logic [31:0] rdata,                           // combinational on offset
  output pad_cfg_u    pad_cfg [num_pads],
  output logic        host_irq
);

  logic [31:0] irq_ctl;                                // bit 0 enable
  logic        wr_en;

  assign wr_en = slv.sel & slv.write;

  //--------------------------------------------------------------------
  // register writes
  //--------------------------------------------------------------------
  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < num_pads; i++) begin
        pad_cfg[i] <= '0;                              // mode_func, no override
      end
      irq_ctl <= 32'h0;                                // host irq off
    end else if (wr_en) begin
      for (int i = 0; i < num_pads; i++) begin
        if (slv.offset == pad_cfg_off + 8'(4 * i)) begin
          pad_cfg[i].raw <= slv.wdata;                 // whole word kept
        end
      end
      if (slv.offset == irq_ctl_off) begin
        irq_ctl <= slv.wdata;
      end
      // sig_off is read only, write dropped
    end
  end

  //--------------------------------------------------------------------
  // read mux
  //--------------------------------------------------------------------
  always_comb begin
    rdata = 32'h0;                                     // holes read 0
    for (int i = 0; i < num_pads; i++) begin
      if (slv.offset == pad_cfg_off + 8'(4 * i)) begin
        rdata = pad_cfg[i].raw;
      end
    end
    if (slv.offset == irq_ctl_off) begin
      rdata = irq_ctl;
    end
    if (slv.offset == sig_off) begin
      rdata = chip_signature;
    end
  end

  // gpio interrupt out to the host when enabled
  assign host_irq = gpio_irq & irq_ctl[0];

endmodule

//--- padring/pad_mux.sv
module pad_mux import chip_pkg::*; (
  input  pad_cfg_u              pad_cfg [num_pads],   // decoded per pad
  input  logic [gpio_w-1:0]     gpio_out,
  input  logic                  host_irq,
  output logic [num_pads-1:0]   pad_drive,            // value to pad
  output logic [pad_ctl_w-1:0]  pad_ctl [num_pads]    // {attr, drive}
);

  //--------------------------------------------------------------------
  // output select
  //--------------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < num_pads; i++) begin
      pad_drive[i] = 1'b0;                             // input mode default
      case (pad_cfg[i].fld.mode)
        mode_func: begin
          pad_drive[i] = gpio_out[i];                  // gpio bit n on pad n
        end
        mode_level: begin
          pad_drive[i] = pad_cfg[i].fld.level;         // static level
        end
        mode_irq: begin
          pad_drive[i] = host_irq;
        end
        mode_input: begin
          pad_drive[i] = 1'b0;                         // not driven
        end
      endcase
    end
  end

  //--------------------------------------------------------------------
  // pad control word
  //--------------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < num_pads; i++) begin
      pad_ctl[i][pad_ctl_w-1:2] = pad_cfg[i].fld.attr;  // straight through
      if (pad_cfg[i].fld.override) begin
        pad_ctl[i][1:0] = pad_cfg[i].fld.drive;        // software forced
      end else if (pad_cfg[i].fld.mode == mode_input) begin
        pad_ctl[i][1:0] = drv_in;
      end else begin
        pad_ctl[i][1:0] = drv_out;                     // every driving mode
      end
    end
  end

endmodule

//--- gpio/gpio_port.sv
module gpio_port import chip_pkg::*; (
  input  logic              hclk,
  input  logic              rst_n,
  input  slv_req_t          slv,
  input  logic [gpio_w-1:0] pad_sense,                 // async from pads
  output logic [31:0]       rdata,                     // combinational on offset
  output logic [gpio_w-1:0] gpio_out,
  output logic              gpio_irq
);

  logic [gpio_w-1:0] sync1;                            // first stage
  logic [gpio_w-1:0] sync2;                            // gpio_in value
  logic [gpio_w-1:0] sync_prev;                        // for edge detect
  logic [gpio_w-1:0] irq_mask;
  logic [gpio_w-1:0] irq_stat;                         // sticky
  logic [gpio_w-1:0] rise;
  logic [gpio_w-1:0] stat_clr;
  logic              wr_en;

  assign wr_en = slv.sel & slv.write;

  //--------------------------------------------------------------------
  // input sync and edge detect
  //--------------------------------------------------------------------
  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      sync1     <= '0;
      sync2     <= '0;
      sync_prev <= '0;
    end else begin
      sync1     <= pad_sense;
      sync2     <= sync1;
      sync_prev <= sync2;
    end
  end

  assign rise     = sync2 & ~sync_prev & irq_mask;     // masked rising edges
  assign stat_clr = (wr_en && slv.offset == gpio_stat_off) ? slv.wdata[gpio_w-1:0] : '0;

  //--------------------------------------------------------------------
  // registers
  //--------------------------------------------------------------------
  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      gpio_out <= '0;
      irq_mask <= '0;                                  // all edges ignored
      irq_stat <= '0;
    end else begin
      if (wr_en && slv.offset == gpio_out_off) begin
        gpio_out <= slv.wdata[gpio_w-1:0];
      end
      if (wr_en && slv.offset == gpio_mask_off) begin
        irq_mask <= slv.wdata[gpio_w-1:0];
      end
      irq_stat <= (irq_stat & ~stat_clr) | rise;       // new edge beats clear
    end
  end

  // read mux, upper bits zero
  always_comb begin
    case (slv.offset)
      gpio_out_off:  rdata = 32'(gpio_out);
      gpio_in_off:   rdata = 32'(sync2);
      gpio_mask_off: rdata = 32'(irq_mask);
      gpio_stat_off: rdata = 32'(irq_stat);
      default:       rdata = 32'h0;
    endcase
  end

  assign gpio_irq = |irq_stat;

endmodule

//--- logic/chip_core.sv
module chip_core import chip_pkg::*; (
  input  logic                  hclk,
  input  logic                  nreset,
  input  bus_req_t              req,
  input  logic                  req_valid,
  output logic                  req_ready,
  output bus_rsp_t              rsp,
  output logic                  rsp_valid,
  input  logic                  rsp_ready,
  input  logic [gpio_w-1:0]     pad_sense,
  output logic [num_pads-1:0]   pad_drive,
  output logic [pad_ctl_w-1:0]  pad_ctl [num_pads],
  output logic                  host_irq
);

  //--------------------------------------------------------------------
  // internal nets
  //--------------------------------------------------------------------
  logic              rst_sync_n;                       // clean reset for all blocks
  slv_req_t          pad_req;
  slv_req_t          gpio_req;
  logic [31:0]       pad_rdata;
  logic [31:0]       gpio_rdata;
  pad_cfg_u          pad_cfg [num_pads];
  logic [gpio_w-1:0] gpio_out;
  logic              gpio_irq;

  reset_sync u_reset_sync (
    .hclk       (hclk),
    .nreset     (nreset),
    .rst_sync_n (rst_sync_n)
  );

  bus_fabric u_bus_fabric (
    .hclk       (hclk),
    .rst_n      (rst_sync_n),
    .req        (req),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .rsp        (rsp),
    .rsp_valid  (rsp_valid),
    .rsp_ready  (rsp_ready),
    .pad_req    (pad_req),
    .pad_rdata  (pad_rdata),
    .gpio_req   (gpio_req),
    .gpio_rdata (gpio_rdata)
  );

  pad_cfg_regs u_pad_cfg_regs (
    .hclk     (hclk),
    .rst_n    (rst_sync_n),
    .slv      (pad_req),
    .gpio_irq (gpio_irq),
    .rdata    (pad_rdata),
    .pad_cfg  (pad_cfg),
    .host_irq (host_irq)                               // also a pad source
  );

  gpio_port u_gpio_port (
    .hclk      (hclk),
    .rst_n     (rst_sync_n),
    .slv       (gpio_req),
    .pad_sense (pad_sense),
    .rdata     (gpio_rdata),
    .gpio_out  (gpio_out),
    .gpio_irq  (gpio_irq)
  );

  pad_mux u_pad_mux (
    .pad_cfg   (pad_cfg),
    .gpio_out  (gpio_out),
    .host_irq  (host_irq),
    .pad_drive (pad_drive),
    .pad_ctl   (pad_ctl)
  );

endmodule

//--- bench/tb_chip_core.sv
module tb_chip_core import chip_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int test_cycles = 500;                    // rough length of all tests
  localparam int max_cycles  = 4 * test_cycles;        // watchdog limit

  logic                 hclk;
  logic                 nreset;
  bus_req_t             req;
  logic                 req_valid;
  logic                 req_ready;
  bus_rsp_t             rsp;
  logic                 rsp_valid;
  logic                 rsp_ready;
  logic [gpio_w-1:0]    pad_sense;
  logic [num_pads-1:0]  pad_drive;
  logic [pad_ctl_w-1:0] pad_ctl [num_pads];
  logic                 host_irq;

  int     errors     = 0;
  int     checks     = 0;
  int     tests      = 0;
  int     test_start = 0;                              // errors before current test
  int     cycles     = 0;
  integer seed       = 32'h4e01_d354;

  chip_core i_dut (.*);

  initial begin
    hclk = 1'b0;
    forever #50 hclk = ~hclk;                          // 100 ns period
  end

  // watchdog
  initial begin
    while (cycles < max_cycles) begin
      @(posedge hclk);
      cycles++;
    end
    $display("timeout: tests still running after %0d cycles", max_cycles);
    $display("*** FAILED ***");
    $finish;
  end

  //--------------------------------------------------------------------
  // helpers
  //--------------------------------------------------------------------
  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge hclk);
    #10;                                               // drive point after the edge
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %-14s done, %0d errors", name, errors - test_start);
    test_start = errors;
  endtask

  // one request, waits for ready, takes the response with rsp_ready high
  task automatic bus_xfer(input logic [31:0] addr, input logic wr, input logic [31:0] wdata,
                          output bus_rsp_t r);
    req       = '{addr: addr, write: wr, wdata: wdata};
    req_valid = 1'b1;
    @(negedge hclk);
    while (!req_ready) begin
      @(negedge hclk);
    end
    wait_cycles(1);                                    // accept edge
    req_valid = 1'b0;
    check("rsp_valid", 1, rsp_valid);                  // one cycle after accept
    r = rsp;
    wait_cycles(1);                                    // response transfers
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    bus_rsp_t r;
    bus_xfer(addr, 1'b1, data, r);
    check("write err", 0, 32'(r.err));
  endtask

  task automatic bus_read(input logic [31:0] addr, output bus_rsp_t r);
    bus_xfer(addr, 1'b0, 32'h0, r);
  endtask

  task automatic read_expect(input string name, input logic [31:0] addr, input logic [31:0] exp);
    bus_rsp_t r;
    bus_read(addr, r);
    check({name, " err"}, 0, 32'(r.err));
    check(name, exp, r.rdata);
  endtask

  //--------------------------------------------------------------------
  // directed tests
  //--------------------------------------------------------------------
  task automatic reset_and_map();
    bus_rsp_t r;
    check("req_ready", 1, req_ready);
    check("rsp_valid", 0, rsp_valid);
    check("host_irq", 0, host_irq);
    check("pad_drive", 0, 32'(pad_drive));
    for (int i = 0; i < num_pads; i++) begin
      check($sformatf("pad_ctl[%0d]", i), {7'h0, drv_out}, pad_ctl[i]);
    end
    read_expect("signature", pad_cfg_base + sig_off, chip_signature);
    bus_write(pad_cfg_base + sig_off, $random(seed));  // read only
    read_expect("signature", pad_cfg_base + sig_off, chip_signature);
    bus_read(32'h4004_0010, r);                        // no slave here
    check("unmapped err", 1, 32'(r.err));
    check("unmapped rdata", 0, r.rdata);
    finish_test("reset_and_map");
  endtask

  task automatic register_readback();
    logic [31:0] addrs [11];
    logic [31:0] exp [11];
    for (int i = 0; i < num_pads; i++) begin
      addrs[i] = pad_cfg_base + pad_cfg_off + 32'(4 * i);
    end
    addrs[8]  = pad_cfg_base + irq_ctl_off;
    addrs[9]  = gpio_base + gpio_out_off;
    addrs[10] = gpio_base + gpio_mask_off;
    for (int i = 0; i < 11; i++) begin
      exp[i] = $random(seed);
      bus_write(addrs[i], exp[i]);
      if (i >= 9) begin
        exp[i] = exp[i] & 32'hff;                      // gpio regs are 8 bits
      end
    end
    for (int i = 0; i < 11; i++) begin
      read_expect($sformatf("rdata@%h", addrs[i]), addrs[i], exp[i]);
    end
    finish_test("readback");
  endtask

  task automatic pad_select();
    logic [31:0] cfg [num_pads];
    logic [7:0]  gout;
    logic        exp_bit;
    logic [1:0]  exp_drv;
    gout = 8'($random(seed));
    bus_write(gpio_base + gpio_out_off, 32'(gout));
    bus_write(pad_cfg_base + irq_ctl_off, 32'h0);      // host_irq held low
    for (int m = 0; m < 4; m++) begin
      for (int ovr = 0; ovr < 2; ovr++) begin
        for (int i = 0; i < num_pads; i++) begin
          // random level, attr, drive; mode and override forced
          cfg[i] = ($random(seed) & 32'h0100_01ff) | (32'(ovr) << 20) | (32'(m) << 16);
          bus_write(pad_cfg_base + 32'(4 * i), cfg[i]);
        end
        for (int i = 0; i < num_pads; i++) begin
          case (m)
            0:       exp_bit = gout[i];
            1:       exp_bit = cfg[i][24];
            default: exp_bit = 1'b0;                   // irq off or input only
          endcase
          exp_drv = (ovr != 0) ? cfg[i][1:0] : ((m == 3) ? drv_in : drv_out);
          check($sformatf("pad_drive[%0d]", i), 32'(exp_bit), 32'(pad_drive[i]));
          check($sformatf("pad_ctl[%0d]", i), {cfg[i][8:2], exp_drv}, pad_ctl[i]);
        end
      end
    end
    finish_test("pad_select");
  endtask

  task automatic input_irq();
    logic [7:0] sense;
    bus_write(gpio_base + gpio_mask_off, 32'h0);
    bus_write(gpio_base + gpio_stat_off, 32'hff);      // drop leftovers
    sense     = 8'($random(seed));
    pad_sense = sense;
    wait_cycles(3);
    read_expect("gpio_in", gpio_base + gpio_in_off, 32'(sense));
    read_expect("gpio_stat", gpio_base + gpio_stat_off, 32'h0);  // all masked
    pad_sense = 8'h00;
    wait_cycles(3);
    bus_write(gpio_base + gpio_mask_off, 32'h0f);
    bus_write(pad_cfg_base + 32'h1c, 32'(mode_irq) << 16);       // pad 7 shows irq
    pad_sense = 8'h11;                                 // bit 0 masked in, bit 4 out
    wait_cycles(3);
    read_expect("gpio_stat", gpio_base + gpio_stat_off, 32'h01);
    check("host_irq", 0, host_irq);                    // enable still off
    check("pad_drive[7]", 0, pad_drive[7]);
    bus_write(pad_cfg_base + irq_ctl_off, 32'h1);
    check("host_irq", 1, host_irq);
    check("pad_drive[7]", 1, pad_drive[7]);
    bus_write(gpio_base + gpio_stat_off, 32'h01);      // write 1 clears
    read_expect("gpio_stat", gpio_base + gpio_stat_off, 32'h0);
    check("host_irq", 0, host_irq);
    check("pad_drive[7]", 0, pad_drive[7]);
    bus_write(pad_cfg_base + irq_ctl_off, 32'h0);
    finish_test("input_irq");
  endtask

  task automatic back_pressure();
    bus_write(pad_cfg_base + pad_cfg_off, 32'h0);      // pad 0 back to gpio bit
    bus_write(gpio_base + gpio_out_off, 32'h0);
    rsp_ready = 1'b0;
    req       = '{addr: pad_cfg_base + sig_off, write: 1'b0, wdata: 32'h0};
    req_valid = 1'b1;
    @(negedge hclk);
    check("req_ready", 1, req_ready);
    wait_cycles(1);                                    // read accepted
    req = '{addr: gpio_base + gpio_out_off, write: 1'b1, wdata: 32'hff};
    for (int c = 0; c < 5; c++) begin
      @(negedge hclk);
      check("req_ready", 0, req_ready);
      check("rsp_valid", 1, rsp_valid);
      check("rsp.rdata", chip_signature, rsp.rdata);   // held stable
      check("rsp.err", 0, 32'(rsp.err));
      check("pad_drive[0]", 0, 32'(pad_drive[0]));     // write not taken yet
      wait_cycles(1);
    end
    rsp_ready = 1'b1;
    @(negedge hclk);
    check("req_ready", 1, req_ready);
    wait_cycles(1);                                    // read out, write in
    req_valid = 1'b0;
    check("rsp_valid", 1, rsp_valid);
    check("rsp.err", 0, 32'(rsp.err));
    check("pad_drive[0]", 1, 32'(pad_drive[0]));
    wait_cycles(1);
    read_expect("gpio_out", gpio_base + gpio_out_off, 32'hff);
    finish_test("back_pressure");
  endtask

  //--------------------------------------------------------------------
  // main sequence
  //--------------------------------------------------------------------
  initial begin
    nreset    = 1'b0;
    req       = '0;
    req_valid = 1'b0;
    rsp_ready = 1'b1;
    pad_sense = '0;
    repeat (4) @(posedge hclk);
    #10;
    nreset = 1'b1;
    wait_cycles(4);                                    // internal release on 3rd edge
    reset_and_map();
    register_readback();
    pad_select();
    input_irq();
    back_pressure();
    $display("tests %0d, checks %0d, errors %0d, cycles %0d", tests, checks, errors, cycles);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- list.f
common/chip_pkg.sv
logic/reset_sync.sv
logic/bus_fabric.sv
padring/pad_cfg_regs.sv
padring/pad_mux.sv
gpio/gpio_port.sv
logic/chip_core.sv
bench/tb_chip_core.sv
